// ==== list.f ====
+incdir+source
source/mmu_pkg.sv
source/dtlb.sv
source/lsu_req_stage.sv
source/xlate_resp.sv
source/mmu_top.sv
verif/mmu_sva.sv
verif/mmu_checker.sv
verif/tb_mmu.sv

// ==== Makefile ====
TOP = tb_mmu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/tb_mmu.sv ====
/*
 * top testbench of the data translation path
 * clock, reset, stimulus table and drive loop, watchdog, dut and checker
 */

`timescale 1ns/1ps
`include "mmu_settings.svh"

module tb_mmu;
  import mmu_pkg::*;

  localparam int NTESTS  = 26;
  localparam int CLK_PER = 40;
  // a request entry takes up to four cycles including the wait for the checker
  localparam int WDOG_NS = (NTESTS * 4 + 20) * CLK_PER;

  // page bases, offsets are added at random per request
  localparam logic [`MMU_VLEN-1:0] VA_BYP = 39'h12_3456_7000;
  localparam logic [`MMU_VLEN-1:0] VA_4K  = 39'h00_4040_3000;
  localparam logic [`MMU_VLEN-1:0] VA_2M  = 39'h01_40e1_1000;
  localparam logic [`MMU_VLEN-1:0] VA_1G  = 39'h40_14a1_f000;
  localparam logic [`MMU_VLEN-1:0] VA_DZ  = 39'h00_8000_9000;
  localparam logic [`MMU_VLEN-1:0] VA_E   = 39'h00_c060_3000;
  localparam logic [`MMU_VLEN-1:0] VA_MIS = 39'h00_0000_5000;

  typedef enum logic [1:0] {
    OP_REQ,
    OP_REFILL,
    OP_FLUSH
  } op_e;

  typedef struct packed {
    logic [8*12-1:0]      name;
    op_e                  op;
    logic                 req;
    logic [`MMU_VLEN-1:0] vaddr;
    logic                 store;
    priv_lvl_e            priv;
    logic                 sum;
    logic                 en;
    logic                 mis;
    logic                 is_2m;
    logic                 is_1g;
    pte_t                 pte;
    logic                 exp_hit;
    logic                 exp_valid;
    logic [`MMU_PPNW-1:0] exp_ppn;
    xcpt_cause_e          exp_cause;
    logic                 exp_xvalid;
  } entry_t;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 clear_i;
  logic                 en_ld_st_translation_i;
  logic                 lsu_req_i;
  logic [`MMU_VLEN-1:0] lsu_vaddr_i;
  logic                 lsu_is_store_i;
  exception_t           misaligned_ex_i;
  priv_lvl_e            ld_st_priv_lvl_i;
  logic                 sum_i;
  logic                 flush_tlb_i;
  tlb_update_t          dtlb_update_i;
  logic                 lsu_dtlb_hit_o;
  logic [`MMU_PPNW-1:0] lsu_dtlb_ppn_o;
  logic                 lsu_valid_o;
  logic [`MMU_PLEN-1:0] lsu_paddr_o;
  exception_t           lsu_exception_o;
  logic                 dtlb_miss_o;

  // expected values handed to the checker with each request
  logic                 chk_en;
  logic [8*12-1:0]      chk_name;
  logic                 exp_hit;
  logic [`MMU_PPNW-1:0] exp_ppn;
  logic                 exp_valid;
  logic [`MMU_PLEN-1:0] exp_paddr;
  xcpt_cause_e          exp_cause;
  logic                 exp_xvalid;
  logic [`MMU_XLEN-1:0] exp_tval;
  logic                 report;
  logic [31:0]          done_cnt;
  logic [31:0]          err_cnt;

  entry_t stim [NTESTS];
  int     n_req;

  always #(CLK_PER / 2) clk_i = ~clk_i;

  mmu_top u_dut (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .clear_i                (clear_i),
    .en_ld_st_translation_i (en_ld_st_translation_i),
    .lsu_req_i              (lsu_req_i),
    .lsu_vaddr_i            (lsu_vaddr_i),
    .lsu_is_store_i         (lsu_is_store_i),
    .misaligned_ex_i        (misaligned_ex_i),
    .ld_st_priv_lvl_i       (ld_st_priv_lvl_i),
    .sum_i                  (sum_i),
    .flush_tlb_i            (flush_tlb_i),
    .dtlb_update_i          (dtlb_update_i),
    .lsu_dtlb_hit_o         (lsu_dtlb_hit_o),
    .lsu_dtlb_ppn_o         (lsu_dtlb_ppn_o),
    .lsu_valid_o            (lsu_valid_o),
    .lsu_paddr_o            (lsu_paddr_o),
    .lsu_exception_o        (lsu_exception_o),
    .dtlb_miss_o            (dtlb_miss_o)
  );

  mmu_checker u_chk (
    .clk_i        (clk_i),
    .req_i        (lsu_req_i),
    .en_i         (en_ld_st_translation_i),
    .hit_i        (lsu_dtlb_hit_o),
    .ppn_i        (lsu_dtlb_ppn_o),
    .miss_i       (dtlb_miss_o),
    .valid_i      (lsu_valid_o),
    .paddr_i      (lsu_paddr_o),
    .exc_i        (lsu_exception_o),
    .chk_en_i     (chk_en),
    .name_i       (chk_name),
    .exp_hit_i    (exp_hit),
    .exp_ppn_i    (exp_ppn),
    .exp_valid_i  (exp_valid),
    .exp_paddr_i  (exp_paddr),
    .exp_cause_i  (exp_cause),
    .exp_xvalid_i (exp_xvalid),
    .exp_tval_i   (exp_tval),
    .report_i     (report),
    .done_o       (done_cnt),
    .err_o        (err_cnt)
  );

  // ----------------------------------------------------------------------------
  // table helpers
  // ----------------------------------------------------------------------------
  // trap value rule, vaddr sign extended to xlen
  function automatic logic [`MMU_XLEN-1:0] sext_vaddr(input logic [`MMU_VLEN-1:0] v);
    return {{(`MMU_XLEN-`MMU_VLEN){v[`MMU_VLEN-1]}}, v};
  endfunction

  function automatic entry_t req_entry(
    input logic [8*12-1:0] name, input logic [`MMU_VLEN-1:0] va, input logic st,
    input priv_lvl_e pv, input logic sm, input logic en, input logic hit,
    input logic vld, input logic [`MMU_PPNW-1:0] eppn, input xcpt_cause_e cause,
    input logic xv);
    entry_t e;
    e            = '0;
    e.name       = name;
    e.op         = OP_REQ;
    e.req        = 1'b1;
    e.vaddr      = va;
    e.store      = st;
    e.priv       = pv;
    e.sum        = sm;
    e.en         = en;
    e.exp_hit    = hit;
    e.exp_valid  = vld;
    e.exp_ppn    = eppn;
    e.exp_cause  = cause;
    e.exp_xvalid = xv;
    return e;
  endfunction

  function automatic entry_t refill_entry(
    input logic [8*12-1:0] name, input logic [`MMU_VLEN-1:0] va, input logic m2,
    input logic g1, input logic [`MMU_PPNW-1:0] ppn, input logic u, input logic w,
    input logic d);
    entry_t e;
    e             = '0;
    e.name        = name;
    e.op          = OP_REFILL;
    e.vaddr       = va;
    e.is_2m       = m2;
    e.is_1g       = g1;
    e.pte.ppn     = ppn;
    e.pte.u       = u;
    e.pte.w       = w;
    e.pte.d       = d;
    return e;
  endfunction

  task automatic build_table();
    entry_t e;
    // bypass, translation off
    stim[0]  = req_entry("byp_ld", VA_BYP, 0, PRIV_S, 0, 0, 1, 1, 44'h123_4567,
                         LOAD_PAGE_FAULT, 0);
    stim[1]  = refill_entry("ref_4k", VA_4K, 0, 0, 44'h12345, 0, 1, 1);
    stim[2]  = refill_entry("ref_2m", VA_2M, 1, 0, 44'habc00, 1, 1, 1);
    stim[3]  = refill_entry("ref_1g", VA_1G, 0, 1, 44'h80000, 0, 0, 1);
    // superpages take the low vpn levels from the vaddr
    stim[4]  = req_entry("ld_4k", VA_4K, 0, PRIV_S, 0, 1, 1, 1, 44'h12345,
                         LOAD_PAGE_FAULT, 0);
    stim[5]  = req_entry("ld_2m_m", VA_2M, 0, PRIV_M, 0, 1, 1, 1, 44'habc11,
                         LOAD_PAGE_FAULT, 0);
    stim[6]  = req_entry("ld_1g", VA_1G, 0, PRIV_S, 0, 1, 1, 1, 44'h94a1f,
                         LOAD_PAGE_FAULT, 0);
    // permissions
    stim[7]  = req_entry("st_1g_w0", VA_1G, 1, PRIV_S, 0, 1, 1, 1, 44'h94a1f,
                         STORE_PAGE_FAULT, 1);
    stim[8]  = req_entry("ld_2m_s", VA_2M, 0, PRIV_S, 0, 1, 1, 1, 44'habc11,
                         LOAD_PAGE_FAULT, 1);
    stim[9]  = req_entry("ld_2m_sum", VA_2M, 0, PRIV_S, 1, 1, 1, 1, 44'habc11,
                         LOAD_PAGE_FAULT, 0);
    stim[10] = req_entry("ld_4k_u", VA_4K, 0, PRIV_U, 0, 1, 1, 1, 44'h12345,
                         LOAD_PAGE_FAULT, 1);
    stim[11] = req_entry("st_2m_u", VA_2M, 1, PRIV_U, 0, 1, 1, 1, 44'habc11,
                         STORE_PAGE_FAULT, 0);
    stim[12] = refill_entry("ref_dz", VA_DZ, 0, 0, 44'h777, 0, 1, 0);
    stim[13] = req_entry("st_dz", VA_DZ, 1, PRIV_S, 0, 1, 1, 1, 44'h777,
                         STORE_PAGE_FAULT, 1);
    // miss, then refill into the oldest slot
    stim[14] = req_entry("miss_e", VA_E, 0, PRIV_S, 0, 1, 0, 0, 44'h0,
                         LOAD_PAGE_FAULT, 0);
    stim[15] = refill_entry("ref_e", VA_E, 0, 0, 44'h333, 0, 1, 1);
    stim[16] = req_entry("ld_e", VA_E, 0, PRIV_S, 0, 1, 1, 1, 44'h333,
                         LOAD_PAGE_FAULT, 0);
    stim[17] = req_entry("ld_4k_gone", VA_4K, 0, PRIV_S, 0, 1, 0, 0, 44'h0,
                         LOAD_PAGE_FAULT, 0);
    stim[18] = req_entry("ld_2m_kept", VA_2M, 0, PRIV_S, 1, 1, 1, 1, 44'habc11,
                         LOAD_PAGE_FAULT, 0);
    stim[19] = req_entry("ld_1g_kept", VA_1G, 0, PRIV_S, 0, 1, 1, 1, 44'h94a1f,
                         LOAD_PAGE_FAULT, 0);
    stim[20] = req_entry("ld_dz_kept", VA_DZ, 0, PRIV_S, 0, 1, 1, 1, 44'h777,
                         LOAD_PAGE_FAULT, 0);
    e        = '0;
    e.name   = "flush";
    e.op     = OP_FLUSH;
    stim[21] = e;
    stim[22] = req_entry("ld_e_flush", VA_E, 0, PRIV_S, 0, 1, 0, 0, 44'h0,
                         LOAD_PAGE_FAULT, 0);
    stim[23] = req_entry("ld_2m_flush", VA_2M, 0, PRIV_S, 1, 1, 0, 0, 44'h0,
                         LOAD_PAGE_FAULT, 0);
    // misaligned wins over the miss and keeps the untranslated address
    stim[24] = req_entry("mis_ld", VA_MIS, 0, PRIV_S, 0, 1, 0, 1, 44'h5,
                         LD_ADDR_MISALIGNED, 1);
    stim[24].mis = 1'b1;
    stim[25] = req_entry("mis_noreq", VA_MIS, 1, PRIV_S, 0, 1, 0, 0, 44'h0,
                         ST_ADDR_MISALIGNED, 0);
    stim[25].mis = 1'b1;
    stim[25].req = 1'b0;
  endtask

  // ----------------------------------------------------------------------------
  // drive
  // ----------------------------------------------------------------------------
  task automatic apply_entry(input entry_t e);
    logic [`MMU_PG_OFFS-1:0] off;
    logic [`MMU_VLEN-1:0]    va;
    tlb_update_t             upd;
    exception_t              mis_ex;
    off = 12'($urandom() % 4096);
    va  = e.vaddr | {{(`MMU_VLEN-`MMU_PG_OFFS){1'b0}}, off};
    @(posedge clk_i);
    case (e.op)
      OP_REFILL: begin
        upd         = '0;
        upd.valid   = 1'b1;
        upd.is_2m   = e.is_2m;
        upd.is_1g   = e.is_1g;
        upd.vpn     = e.vaddr[`MMU_VLEN-1:`MMU_PG_OFFS];
        upd.content = e.pte;
        dtlb_update_i <= upd;
        @(posedge clk_i);
        dtlb_update_i <= '0;
      end
      OP_FLUSH: begin
        flush_tlb_i <= 1'b1;
        @(posedge clk_i);
        flush_tlb_i <= 1'b0;
      end
      default: begin
        mis_ex       = '0;
        mis_ex.valid = e.mis;
        mis_ex.tval  = sext_vaddr(va);
        if (e.store) begin
          mis_ex.cause = ST_ADDR_MISALIGNED;
        end else begin
          mis_ex.cause = LD_ADDR_MISALIGNED;
        end
        en_ld_st_translation_i <= e.en;
        ld_st_priv_lvl_i       <= e.priv;
        sum_i                  <= e.sum;
        lsu_req_i              <= e.req;
        lsu_vaddr_i            <= va;
        lsu_is_store_i         <= e.store;
        misaligned_ex_i        <= mis_ex;
        chk_en                 <= 1'b1;
        chk_name               <= e.name;
        exp_hit                <= e.exp_hit;
        exp_ppn                <= e.exp_ppn;
        exp_valid              <= e.exp_valid;
        exp_paddr              <= {e.exp_ppn, off};
        exp_cause              <= e.exp_cause;
        exp_xvalid             <= e.exp_xvalid;
        exp_tval               <= sext_vaddr(va);
        n_req = n_req + 1;
        // context stays put, the response reads it in the next cycle
        @(posedge clk_i);
        lsu_req_i       <= 1'b0;
        misaligned_ex_i <= '0;
        chk_en          <= 1'b0;
        while (done_cnt != n_req) begin
          @(posedge clk_i);
        end
      end
    endcase
  endtask

  initial begin
    void'($urandom(6));
    clk_i                  = 1'b0;
    rst_n_i                = 1'b0;
    clear_i                = 1'b0;
    en_ld_st_translation_i = 1'b0;
    lsu_req_i              = 1'b0;
    lsu_vaddr_i            = '0;
    lsu_is_store_i         = 1'b0;
    misaligned_ex_i        = '0;
    ld_st_priv_lvl_i       = PRIV_M;
    sum_i                  = 1'b0;
    flush_tlb_i            = 1'b0;
    dtlb_update_i          = '0;
    chk_en                 = 1'b0;
    chk_name               = '0;
    exp_hit                = 1'b0;
    exp_ppn                = '0;
    exp_valid              = 1'b0;
    exp_paddr              = '0;
    exp_cause              = LOAD_PAGE_FAULT;
    exp_xvalid             = 1'b0;
    exp_tval               = '0;
    report                 = 1'b0;
    n_req                  = 0;
    build_table();
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (int i = 0; i < NTESTS; i++) begin
      apply_entry(stim[i]);
    end
    @(posedge clk_i);
    report <= 1'b1;
    repeat (2) @(posedge clk_i);
    if (err_cnt == 0 && done_cnt == n_req && u_dut.u_sva.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WDOG_NS);
    $display("timeout: the run did not finish, the dut or checker hung");
    $display("tests failed");
    $finish;
  end

endmodule

// ==== verif/mmu_checker.sv ====
/*
 * response checker for the data translation path
 * compares cycle 0 and cycle 1 outputs with the expected values
 */

`timescale 1ns/1ps
`include "mmu_settings.svh"

module mmu_checker (
  input  logic                 clk_i,
  input  logic                 req_i,
  input  logic                 en_i,
  input  logic                 hit_i,
  input  logic [`MMU_PPNW-1:0] ppn_i,
  input  logic                 miss_i,
  input  logic                 valid_i,
  input  logic [`MMU_PLEN-1:0] paddr_i,
  input  mmu_pkg::exception_t  exc_i,
  input  logic                 chk_en_i,
  input  logic [8*12-1:0]      name_i,
  input  logic                 exp_hit_i,
  input  logic [`MMU_PPNW-1:0] exp_ppn_i,
  input  logic                 exp_valid_i,
  input  logic [`MMU_PLEN-1:0] exp_paddr_i,
  input  mmu_pkg::xcpt_cause_e exp_cause_i,
  input  logic                 exp_xvalid_i,
  input  logic [`MMU_XLEN-1:0] exp_tval_i,
  input  logic                 report_i,
  output logic [31:0]          done_o,
  output logic [31:0]          err_o
);
  import mmu_pkg::*;

  logic                 pend;
  logic                 bad;
  logic [8*12-1:0]      p_name;
  logic                 p_valid;
  logic [`MMU_PLEN-1:0] p_paddr;
  xcpt_cause_e          p_cause;
  logic                 p_xvalid;
  logic [`MMU_XLEN-1:0] p_tval;
  int                   pass_cnt;

  initial begin
    pend     = 1'b0;
    bad      = 1'b0;
    done_o   = '0;
    err_o    = '0;
    pass_cnt = 0;
  end

  task automatic report_mismatch(input logic [8*12-1:0] name, input string field,
                                 input logic [63:0] exp, input logic [63:0] got);
    $display("ERR %0s %0s expected %0h actual %0h", name, field, exp, got);
    bad = 1'b1;
  endtask

  // outputs are settled by the falling edge
  always @(negedge clk_i) begin
    // cycle 1 of the pending request
    if (pend) begin
      if (valid_i !== p_valid) begin
        report_mismatch(p_name, "valid", 64'(p_valid), 64'(valid_i));
      end
      if (p_valid && paddr_i !== p_paddr) begin
        report_mismatch(p_name, "paddr", 64'(p_paddr), 64'(paddr_i));
      end
      if (exc_i.valid !== p_xvalid) begin
        report_mismatch(p_name, "xcpt_valid", 64'(p_xvalid), 64'(exc_i.valid));
      end
      if (p_xvalid && exc_i.cause !== p_cause) begin
        report_mismatch(p_name, "cause", 64'(p_cause), 64'(exc_i.cause));
      end
      if (p_xvalid && exc_i.tval !== p_tval) begin
        report_mismatch(p_name, "tval", p_tval, exc_i.tval);
      end
      if (bad) begin
        err_o = err_o + 1;
        $display("FAIL %0s", p_name);
      end else begin
        pass_cnt = pass_cnt + 1;
        $display("ok   %0s", p_name);
      end
      done_o = done_o + 1;
      pend   = 1'b0;
    end
    // cycle 0 of a new request
    if (chk_en_i) begin
      bad = 1'b0;
      if (req_i) begin
        if (hit_i !== exp_hit_i) begin
          report_mismatch(name_i, "hit", 64'(exp_hit_i), 64'(hit_i));
        end
        // page number is only defined on a hit
        if (exp_hit_i && ppn_i !== exp_ppn_i) begin
          report_mismatch(name_i, "ppn", 64'(exp_ppn_i), 64'(ppn_i));
        end
        // miss strobe only with translation on and no hit
        if (miss_i !== (en_i && !exp_hit_i)) begin
          report_mismatch(name_i, "miss", 64'(en_i && !exp_hit_i), 64'(miss_i));
        end
      end else if (miss_i) begin
        $display("%0s: miss strobe raised without a request", name_i);
        bad = 1'b1;
      end
      p_name   = name_i;
      p_valid  = exp_valid_i;
      p_paddr  = exp_paddr_i;
      p_cause  = exp_cause_i;
      p_xvalid = exp_xvalid_i;
      p_tval   = exp_tval_i;
      pend     = 1'b1;
    end
  end

  always @(posedge report_i) begin
    $display("checks run %0d, passed %0d, failed %0d", done_o, pass_cnt, err_o);
  end

endmodule

// ==== verif/mmu_sva.sv ====
/*
 * timing assertions on the translation unit ports, bound into mmu_top
 */

`timescale 1ns/1ps

module mmu_sva (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                lsu_req_i,
  input logic                en_ld_st_translation_i,
  input logic                lsu_valid_o,
  input logic                dtlb_miss_o,
  input mmu_pkg::exception_t lsu_exception_o
);

  int unsigned fail_cnt = 0;

  // response valid only one cycle after a request
  a_valid_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lsu_valid_o |-> $past(lsu_req_i))
    else begin
      fail_cnt++;
      $error("lsu_valid_o without a request in the previous cycle");
    end

  a_miss_with_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dtlb_miss_o |-> lsu_req_i)
    else begin
      fail_cnt++;
      $error("dtlb_miss_o without lsu_req_i");
    end

  // translated exceptions always come with a valid response
  a_xcpt_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (lsu_exception_o.valid && en_ld_st_translation_i) |-> lsu_valid_o)
    else begin
      fail_cnt++;
      $error("exception valid without lsu_valid_o");
    end

endmodule

bind mmu_top mmu_sva u_sva (
  .clk_i                  (clk_i),
  .rst_n_i                (rst_n_i),
  .lsu_req_i              (lsu_req_i),
  .en_ld_st_translation_i (en_ld_st_translation_i),
  .lsu_valid_o            (lsu_valid_o),
  .dtlb_miss_o            (dtlb_miss_o),
  .lsu_exception_o        (lsu_exception_o)
);

// ==== source/mmu_top.sv ====
/*
 * data side sv39 translation unit
 * dtlb, request stage and cycle 1 response
 */

`timescale 1ns/1ps
`include "mmu_settings.svh"

module mmu_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 clear_i,
  input  logic                 en_ld_st_translation_i,
  // lsu request
  input  logic                 lsu_req_i,
  input  logic [`MMU_VLEN-1:0] lsu_vaddr_i,
  input  logic                 lsu_is_store_i,
  input  mmu_pkg::exception_t  misaligned_ex_i,
  // privilege context
  input  mmu_pkg::priv_lvl_e   ld_st_priv_lvl_i,
  input  logic                 sum_i,
  // tlb maintenance
  input  logic                 flush_tlb_i,
  input  mmu_pkg::tlb_update_t dtlb_update_i,
  // cycle 0
  output logic                 lsu_dtlb_hit_o,
  output logic [`MMU_PPNW-1:0] lsu_dtlb_ppn_o,
  // cycle 1
  output logic                 lsu_valid_o,
  output logic [`MMU_PLEN-1:0] lsu_paddr_o,
  output mmu_pkg::exception_t  lsu_exception_o,
  output logic                 dtlb_miss_o
);
  import mmu_pkg::*;

  tlb_lookup_t dtlb_lu;
  stage_t      req_stage;

  // --------------------------------------------------------------------------
  // data tlb
  // --------------------------------------------------------------------------
  dtlb u_dtlb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_tlb_i),
    .update_i   (dtlb_update_i),
    .lu_vaddr_i (lsu_vaddr_i),
    .lu_o       (dtlb_lu)
  );

  // cycle 0 answer and pipeline register
  lsu_req_stage u_req_stage (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .clear_i                (clear_i),
    .en_ld_st_translation_i (en_ld_st_translation_i),
    .lsu_req_i              (lsu_req_i),
    .lsu_vaddr_i            (lsu_vaddr_i),
    .lsu_is_store_i         (lsu_is_store_i),
    .misaligned_ex_i        (misaligned_ex_i),
    .lu_i                   (dtlb_lu),
    .lsu_dtlb_hit_o         (lsu_dtlb_hit_o),
    .lsu_dtlb_ppn_o         (lsu_dtlb_ppn_o),
    .dtlb_miss_o            (dtlb_miss_o),
    .stage_o                (req_stage)
  );

  // cycle 1 response
  xlate_resp u_resp (
    .en_ld_st_translation_i (en_ld_st_translation_i),
    .ld_st_priv_lvl_i       (ld_st_priv_lvl_i),
    .sum_i                  (sum_i),
    .stage_i                (req_stage),
    .lsu_valid_o            (lsu_valid_o),
    .lsu_paddr_o            (lsu_paddr_o),
    .lsu_exception_o        (lsu_exception_o)
  );

endmodule

// ==== source/xlate_resp.sv ====
/*
 * cycle 1 response to the lsu
 * physical address assembly, page permission checks, exception select
 */

`timescale 1ns/1ps
`include "mmu_settings.svh"

module xlate_resp (
  input  logic                 en_ld_st_translation_i,
  input  mmu_pkg::priv_lvl_e   ld_st_priv_lvl_i,
  input  logic                 sum_i,
  input  mmu_pkg::stage_t      stage_i,
  output logic                 lsu_valid_o,
  output logic [`MMU_PLEN-1:0] lsu_paddr_o,
  output mmu_pkg::exception_t  lsu_exception_o
);
  import mmu_pkg::*;

  localparam int unsigned OFFS = `MMU_PG_OFFS;

  pte_t                 pte;
  logic [`MMU_XLEN-1:0] tval_sext;
  logic                 priv_err;

  assign pte = stage_i.lookup.content;

  // faulting vaddr sign extended to xlen
  assign tval_sext = {{(`MMU_XLEN-`MMU_VLEN){stage_i.vaddr[`MMU_VLEN-1]}}, stage_i.vaddr};

  // supervisor on a user page needs sum
  // user mode may only touch user pages
  // machine mode is never checked here
  assign priv_err = ((ld_st_priv_lvl_i == PRIV_S) && !sum_i && pte.u)
                  || ((ld_st_priv_lvl_i == PRIV_U) && !pte.u);

  // --------------------------------------------------------------------------
  // response
  // --------------------------------------------------------------------------
  always_comb begin : resp
    // bypass default
    // vaddr is narrower than paddr so the upper bits stay zero
    lsu_valid_o     = stage_i.req;
    lsu_paddr_o     = {{(`MMU_PLEN-`MMU_VLEN){1'b0}}, stage_i.vaddr};
    lsu_exception_o = stage_i.misaligned;

    // misaligned traps win over anything from translation
    if (en_ld_st_translation_i && !stage_i.misaligned.valid) begin
      lsu_valid_o = 1'b0;
      lsu_paddr_o = {pte.ppn, stage_i.vaddr[OFFS-1:0]};
      // mega page
      if (stage_i.lookup.is_2m) begin
        lsu_paddr_o[OFFS+`MMU_VPNW-1:OFFS] = stage_i.vaddr[OFFS+`MMU_VPNW-1:OFFS];
      end
      // giga page
      if (stage_i.lookup.is_1g) begin
        lsu_paddr_o[OFFS+2*`MMU_VPNW-1:OFFS] = stage_i.vaddr[OFFS+2*`MMU_VPNW-1:OFFS];
      end
      lsu_exception_o.tval = tval_sext;

      // a miss stays invalid and the lsu retries after refill
      if (stage_i.lookup.hit && stage_i.req) begin
        lsu_valid_o = 1'b1;
        if (stage_i.is_store) begin
          // store needs write permission and the dirty bit already set
          if (!pte.w || !pte.d || priv_err) begin
            lsu_exception_o.cause = STORE_PAGE_FAULT;
            lsu_exception_o.valid = 1'b1;
          end
        end else if (priv_err) begin
          lsu_exception_o.cause = LOAD_PAGE_FAULT;
          lsu_exception_o.valid = 1'b1;
        end
      end
    end
  end

endmodule

// ==== source/lsu_req_stage.sv ====
/*
 * cycle 0 hit and ppn answer to the lsu
 * miss strobe and the register between lookup and response
 */

`timescale 1ns/1ps
`include "mmu_settings.svh"

module lsu_req_stage (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 clear_i,
  input  logic                 en_ld_st_translation_i,
  input  logic                 lsu_req_i,
  input  logic [`MMU_VLEN-1:0] lsu_vaddr_i,
  input  logic                 lsu_is_store_i,
  input  mmu_pkg::exception_t  misaligned_ex_i,
  input  mmu_pkg::tlb_lookup_t lu_i,
  output logic                 lsu_dtlb_hit_o,
  output logic [`MMU_PPNW-1:0] lsu_dtlb_ppn_o,
  output logic                 dtlb_miss_o,
  output mmu_pkg::stage_t      stage_o
);
  import mmu_pkg::*;

  localparam int unsigned VPN_W = `MMU_VLEN - `MMU_PG_OFFS;

  stage_t stage_d;
  stage_t stage_q;

  // --------------------------------------------------------------------------
  // cycle 0
  // --------------------------------------------------------------------------
  // no translation means always ready
  assign lsu_dtlb_hit_o = en_ld_st_translation_i ? lu_i.hit : 1'b1;
  assign dtlb_miss_o    = en_ld_st_translation_i & lsu_req_i & ~lu_i.hit;

  always_comb begin : ppn_sel
    if (en_ld_st_translation_i) begin
      lsu_dtlb_ppn_o = lu_i.content.ppn;
      // mega page keeps vpn level 0 of the request
      if (lu_i.is_2m) begin
        lsu_dtlb_ppn_o[`MMU_VPNW-1:0] = lsu_vaddr_i[`MMU_PG_OFFS+`MMU_VPNW-1:`MMU_PG_OFFS];
      end
      // giga page keeps levels 1 and 0
      if (lu_i.is_1g) begin
        lsu_dtlb_ppn_o[2*`MMU_VPNW-1:0] =
          lsu_vaddr_i[`MMU_PG_OFFS+2*`MMU_VPNW-1:`MMU_PG_OFFS];
      end
    end else begin
      lsu_dtlb_ppn_o = {{(`MMU_PPNW-VPN_W){1'b0}}, lsu_vaddr_i[`MMU_VLEN-1:`MMU_PG_OFFS]};
    end
  end

  // --------------------------------------------------------------------------
  // pipeline register
  // --------------------------------------------------------------------------
  always_comb begin : stage_next
    stage_d.vaddr      = lsu_vaddr_i;
    stage_d.req        = lsu_req_i;
    stage_d.is_store   = lsu_is_store_i;
    stage_d.misaligned = misaligned_ex_i;
    // a misaligned flag without a request must not raise a trap
    stage_d.misaligned.valid = misaligned_ex_i.valid & lsu_req_i;
    stage_d.lookup     = lu_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stage_q <= '0;
    end else if (clear_i) begin
      stage_q <= '0;
    end else begin
      stage_q <= stage_d;
    end
  end

  assign stage_o = stage_q;

endmodule

// ==== source/dtlb.sv ====
/*
 * fully associative data tlb
 * 4k, 2m and 1g pages, combinational lookup
 * round robin refill and whole-tlb flush
 */

`timescale 1ns/1ps
`include "mmu_settings.svh"

module dtlb #(
  parameter int unsigned ENTRIES = `MMU_DTLB_ENTRIES
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  input  mmu_pkg::tlb_update_t update_i,
  input  logic [`MMU_VLEN-1:0] lu_vaddr_i,
  output mmu_pkg::tlb_lookup_t lu_o
);
  import mmu_pkg::*;

  localparam int unsigned VPN_W = 3 * `MMU_VPNW;
  localparam int unsigned PTR_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

  // tag and content arrays
  logic [VPN_W-1:0]   tag_vpn_q [ENTRIES];
  logic               tag_2m_q  [ENTRIES];
  logic               tag_1g_q  [ENTRIES];
  logic [ENTRIES-1:0] tag_valid_q;
  pte_t               content_q [ENTRIES];
  // next slot to be replaced
  logic [PTR_W-1:0]   repl_ptr_q;

  logic [VPN_W-1:0]   lu_vpn;
  logic [ENTRIES-1:0] match;

  assign lu_vpn = lu_vaddr_i[`MMU_VLEN-1:`MMU_PG_OFFS];

  // --------------------------------------------------------------------------
  // lookup
  // --------------------------------------------------------------------------
  // superpages ignore the lower vpn levels
  always_comb begin : tag_match
    for (int i = 0; i < ENTRIES; i++) begin
      match[i] = tag_valid_q[i]
               && (tag_vpn_q[i][VPN_W-1 -: `MMU_VPNW] == lu_vpn[VPN_W-1 -: `MMU_VPNW]);
      // level 1 unless giga page
      if (!tag_1g_q[i]) begin
        match[i] = match[i]
                 && (tag_vpn_q[i][2*`MMU_VPNW-1 -: `MMU_VPNW]
                     == lu_vpn[2*`MMU_VPNW-1 -: `MMU_VPNW]);
      end
      // level 0 only for 4k pages
      if (!tag_1g_q[i] && !tag_2m_q[i]) begin
        match[i] = match[i] && (tag_vpn_q[i][`MMU_VPNW-1:0] == lu_vpn[`MMU_VPNW-1:0]);
      end
    end
  end

  // lowest matching slot wins
  always_comb begin : lu_mux
    lu_o = '0;
    for (int i = ENTRIES - 1; i >= 0; i--) begin
      if (match[i]) begin
        lu_o.hit     = 1'b1;
        lu_o.is_2m   = tag_2m_q[i];
        lu_o.is_1g   = tag_1g_q[i];
        lu_o.content = content_q[i];
      end
    end
  end

  // --------------------------------------------------------------------------
  // refill and flush
  // --------------------------------------------------------------------------
  // flush first, then the refill sets its own slot again
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tag_valid_q <= '0;
      repl_ptr_q  <= '0;
    end else begin
      if (flush_i) begin
        tag_valid_q <= '0;
      end
      if (update_i.valid) begin
        tag_valid_q[repl_ptr_q] <= 1'b1;
        // wrap explicitly for non power of two depths
        if (repl_ptr_q == PTR_W'(ENTRIES - 1)) begin
          repl_ptr_q <= '0;
        end else begin
          repl_ptr_q <= repl_ptr_q + 1'b1;
        end
      end
    end
  end

  // payload of the replaced slot
  always_ff @(posedge clk_i) begin
    if (update_i.valid) begin
      tag_vpn_q[repl_ptr_q] <= update_i.vpn;
      tag_2m_q[repl_ptr_q]  <= update_i.is_2m;
      tag_1g_q[repl_ptr_q]  <= update_i.is_1g;
      content_q[repl_ptr_q] <= update_i.content;
    end
  end

endmodule

// ==== source/mmu_pkg.sv ====
/*
 * shared types of the data translation path
 * privilege and exception enums, pte, tlb refill and lookup records,
 * request stage register layout
 */

`include "mmu_settings.svh"

package mmu_pkg;

  // --------------------------------------------------------------------------
  // enums
  // --------------------------------------------------------------------------
  // encoding follows the privileged spec, level 2 is reserved
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_lvl_e;

  // mcause values for the data side only
  typedef enum logic [5:0] {
    LD_ADDR_MISALIGNED = 6'd4,
    ST_ADDR_MISALIGNED = 6'd6,
    LOAD_PAGE_FAULT    = 6'd13,
    STORE_PAGE_FAULT   = 6'd15
  } xcpt_cause_e;

  // --------------------------------------------------------------------------
  // records
  // --------------------------------------------------------------------------
  // leaf pte bits used by the data checks
  typedef struct packed {
    logic [`MMU_PPNW-1:0] ppn;
    logic                 d;
    logic                 u;
    logic                 w;
  } pte_t;

  typedef struct packed {
    xcpt_cause_e          cause;
    logic [`MMU_XLEN-1:0] tval;
    logic                 valid;
  } exception_t;

  // one refill beat, vpn holds all three levels
  typedef struct packed {
    logic                   valid;
    logic                   is_2m;
    logic                   is_1g;
    logic [3*`MMU_VPNW-1:0] vpn;
    pte_t                   content;
  } tlb_update_t;

  typedef struct packed {
    logic hit;
    logic is_2m;
    logic is_1g;
    pte_t content;
  } tlb_lookup_t;

  // request and lookup held between cycle 0 and cycle 1
  typedef struct packed {
    logic [`MMU_VLEN-1:0] vaddr;
    logic                 req;
    logic                 is_store;
    exception_t           misaligned;
    tlb_lookup_t          lookup;
  } stage_t;

endpackage

// ==== source/mmu_settings.svh ====
/*
 * address widths, page geometry and TLB depth for the SV39 data
 * translation path
 */

`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// ----------------------------------------------------------------------------
// address space
// ----------------------------------------------------------------------------
// sv39 virtual address
`define MMU_VLEN 39
// physical address and page number
`define MMU_PLEN 56
`define MMU_PPNW 44
// trap value register width
`define MMU_XLEN 64

// ----------------------------------------------------------------------------
// page geometry
// ----------------------------------------------------------------------------
// bits per vpn level, three levels in sv39
`define MMU_VPNW 9
`define MMU_PG_OFFS 12
`define MMU_DTLB_ENTRIES 4

`endif
